/* hdl/dmc_params.svh */
// DMC channel parameters
`ifndef DMC_PARAMS_SVH
`define DMC_PARAMS_SVH

// Sample memory layout
`define DMC_ADDR_BASE 'hC000
`define DMC_ADDR_UNIT 64
`define DMC_LEN_UNIT 16

// Output bit periods in aclk cycles, slowest first
`define DMC_RATE_0 214
`define DMC_RATE_1 190
`define DMC_RATE_2 170
`define DMC_RATE_3 160
`define DMC_RATE_4 143
`define DMC_RATE_5 127
`define DMC_RATE_6 113
`define DMC_RATE_7 107
`define DMC_RATE_8 95
`define DMC_RATE_9 80
`define DMC_RATE_10 71
`define DMC_RATE_11 64
`define DMC_RATE_12 53
`define DMC_RATE_13 42
`define DMC_RATE_14 36
`define DMC_RATE_15 27

// Top of the 7-bit output counter
`define DMC_LEVEL_MAX 127

`endif

/* hdl/dmc_pkg.sv */
// DMC channel types
package dmc_pkg;

	typedef logic [7:0] sample_t;	// Sample or register byte
	typedef logic [6:0] level_t;	// DAC output level
	typedef logic [15:0] addr_t;	// CPU address
	typedef logic [11:0] length_t;	// Bytes left to fetch
	typedef logic [3:0] rate_idx_t;	// Index into the period table
	typedef logic [7:0] period_t;	// Rate timer count
	typedef logic [2:0] bit_idx_t;	// Position in the shift register

	// Fetch engine
	typedef enum logic [1:0] {
		IDLE,	// Bus left to the CPU
		STALL,	// RDY low, waiting for a read cycle
		GRANT	// DMC owns the address bus
	} fetch_state_t;

endpackage

/* hdl/dmc_cfg_if.sv */
// DMC register settings bundle
`timescale 1ns/10ps

interface dmc_cfg_if;

	dmc_pkg::rate_idx_t rate_idx;	// $4010 bits 3:0
	logic loop;			// $4010 bit 6
	logic irq_en;			// $4010 bit 7
	dmc_pkg::sample_t start_byte;	// $4012
	dmc_pkg::sample_t length_byte;	// $4013
	logic enable;			// $4015 bit 4
	logic enable_wr;		// Strobe of any $4015 write

	modport regs (
		output rate_idx, loop, irq_en, start_byte, length_byte, enable, enable_wr
	);

	modport timer (
		input rate_idx
	);

	modport reader (
		input loop, irq_en, start_byte, length_byte, enable, enable_wr
	);

endinterface

/* hdl/dmc_regs.sv */
// DMC channel registers
`timescale 1ns/10ps

module dmc_regs (
	input logic aclk,
	input logic reset,
	input dmc_pkg::sample_t data_in,
	input logic w4010,
	input logic w4011,
	input logic w4012,
	input logic w4013,
	input logic w4015,
	dmc_cfg_if.regs cfg,
	output logic level_load,
	output dmc_pkg::level_t level_value
);

	always_ff @(posedge aclk) begin
		if (reset) begin
			cfg.rate_idx <= '0;
			cfg.loop <= 1'b0;
			cfg.irq_en <= 1'b0;
			cfg.start_byte <= '0;
			cfg.length_byte <= '0;
			cfg.enable <= 1'b0;
		end else begin
			if (w4010) begin
				cfg.rate_idx <= data_in[3:0];	// Frequency select
				cfg.loop <= data_in[6];
				cfg.irq_en <= data_in[7];
			end
			if (w4012)
				cfg.start_byte <= data_in;	// Address = C000 + 64*A
			if (w4013)
				cfg.length_byte <= data_in;	// Length = 16*L + 1
			if (w4015)
				cfg.enable <= data_in[4];
		end
	end

	// The reader needs the strobe itself, not only the stored bit
	assign cfg.enable_wr = w4015;

	// Direct load of the output counter, bit 7 ignored
	assign level_load = w4011;
	assign level_value = data_in[6:0];

endmodule

/* hdl/dmc_rate_timer.sv */
// DMC output rate timer
`timescale 1ns/10ps
`include "dmc_params.svh"

module dmc_rate_timer (
	input logic aclk,
	input logic reset,
	dmc_cfg_if.timer cfg,
	output logic tick
);

	dmc_pkg::period_t count;	// Cycles left in this period
	dmc_pkg::period_t period;	// Selected table entry

	always_comb begin
		case (cfg.rate_idx)
			4'd0: period = dmc_pkg::period_t'(`DMC_RATE_0);
			4'd1: period = dmc_pkg::period_t'(`DMC_RATE_1);
			4'd2: period = dmc_pkg::period_t'(`DMC_RATE_2);
			4'd3: period = dmc_pkg::period_t'(`DMC_RATE_3);
			4'd4: period = dmc_pkg::period_t'(`DMC_RATE_4);
			4'd5: period = dmc_pkg::period_t'(`DMC_RATE_5);
			4'd6: period = dmc_pkg::period_t'(`DMC_RATE_6);
			4'd7: period = dmc_pkg::period_t'(`DMC_RATE_7);
			4'd8: period = dmc_pkg::period_t'(`DMC_RATE_8);
			4'd9: period = dmc_pkg::period_t'(`DMC_RATE_9);
			4'd10: period = dmc_pkg::period_t'(`DMC_RATE_10);
			4'd11: period = dmc_pkg::period_t'(`DMC_RATE_11);
			4'd12: period = dmc_pkg::period_t'(`DMC_RATE_12);
			4'd13: period = dmc_pkg::period_t'(`DMC_RATE_13);
			4'd14: period = dmc_pkg::period_t'(`DMC_RATE_14);
			default: period = dmc_pkg::period_t'(`DMC_RATE_15);	// Index 15
		endcase
	end

	// Tick on the reload cycle, so one tick per table period
	assign tick = (count == '0);

	always_ff @(posedge aclk) begin
		if (reset)
			count <= '0;
		else if (tick)
			count <= period - 8'd1;
		else
			count <= count - 8'd1;
	end

endmodule

/* hdl/dmc_reader.sv */
// DMC sample fetch engine
`timescale 1ns/10ps
`include "dmc_params.svh"

module dmc_reader (
	input logic aclk,
	input logic reset,
	dmc_cfg_if.reader cfg,
	input logic cpu_read,
	input dmc_pkg::sample_t data_in,
	input logic buf_take,
	output logic rdy,
	output logic dmc_ab,
	output dmc_pkg::addr_t dmc_addr,
	output logic buf_full,
	output dmc_pkg::sample_t buf_data,
	output logic dmc_int,
	output logic dmc_active
);

	dmc_pkg::fetch_state_t state;
	dmc_pkg::addr_t addr_cnt;	// Next fetch address
	dmc_pkg::length_t length_cnt;	// Bytes still to fetch
	dmc_pkg::addr_t start_addr;
	dmc_pkg::length_t start_length;
	logic restart_pend;		// $4015 write seen last cycle
	logic fetch_req;
	logic last_byte;

	assign start_addr = dmc_pkg::addr_t'(`DMC_ADDR_BASE + `DMC_ADDR_UNIT * cfg.start_byte);
	assign start_length = dmc_pkg::length_t'(`DMC_LEN_UNIT * cfg.length_byte + 1);

	assign dmc_active = (length_cnt != '0);
	assign fetch_req = cfg.enable && !buf_full && dmc_active;
	assign last_byte = (length_cnt == 12'd1);

	assign rdy = (state == dmc_pkg::IDLE);	// CPU halted in STALL and GRANT
	assign dmc_ab = (state == dmc_pkg::GRANT);
	assign dmc_addr = addr_cnt;

	always_ff @(posedge aclk) begin
		if (reset) begin
			state <= dmc_pkg::IDLE;
		end else begin
			case (state)
				dmc_pkg::IDLE:
					if (fetch_req)
						state <= dmc_pkg::STALL;
				dmc_pkg::STALL:
					if (cpu_read)
						state <= dmc_pkg::GRANT;	// Only a read cycle can be halted
				default:
					state <= dmc_pkg::IDLE;		// One bus cycle per byte
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			addr_cnt <= '0;
			length_cnt <= '0;
			buf_full <= 1'b0;
			dmc_int <= 1'b0;
			restart_pend <= 1'b0;
		end else begin
			restart_pend <= cfg.enable_wr;
			if (dmc_ab) begin
				buf_full <= 1'b1;
				// Address bit 15 stays set on wrap
				addr_cnt <= (addr_cnt == 16'hFFFF) ? 16'h8000 : addr_cnt + 16'd1;
				length_cnt <= length_cnt - 12'd1;
				if (last_byte && cfg.loop) begin
					addr_cnt <= start_addr;
					length_cnt <= start_length;
				end else if (last_byte && cfg.irq_en) begin
					dmc_int <= 1'b1;
				end
			end else if (buf_take) begin
				buf_full <= 1'b0;
			end
			// Enable bit has landed by now
			if (restart_pend) begin
				if (!cfg.enable) begin
					length_cnt <= '0;
				end else if (!dmc_active) begin
					addr_cnt <= start_addr;
					length_cnt <= start_length;
				end
			end
			if (cfg.enable_wr)
				dmc_int <= 1'b0;	// Any $4015 write acknowledges
		end
	end

	always_ff @(posedge aclk) begin
		if (dmc_ab)
			buf_data <= data_in;
	end

endmodule

/* hdl/dmc_output_unit.sv */
// DMC output shifter and level counter
`timescale 1ns/10ps
`include "dmc_params.svh"

module dmc_output_unit (
	input logic aclk,
	input logic reset,
	input logic tick,
	input logic buf_full,
	input dmc_pkg::sample_t buf_data,
	input logic level_load,
	input dmc_pkg::level_t level_value,
	output logic buf_take,
	output dmc_pkg::level_t dmc_out
);

	dmc_pkg::sample_t shift_reg;	// Current byte, LSB goes out first
	dmc_pkg::bit_idx_t bit_cnt;
	logic silence;			// No byte was ready at the last wrap
	logic bit_wrap;
	logic step_up;
	logic step_down;

	assign bit_wrap = (bit_cnt == 3'd7);
	assign buf_take = tick && bit_wrap && buf_full;

	// Saturate at both ends instead of wrapping
	assign step_up = shift_reg[0] &&
		(dmc_out <= dmc_pkg::level_t'(`DMC_LEVEL_MAX - 2));
	assign step_down = !shift_reg[0] && (dmc_out >= 7'd2);

	always_ff @(posedge aclk) begin
		if (reset) begin
			bit_cnt <= '0;
			silence <= 1'b1;
		end else if (tick) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_wrap)
				silence <= !buf_full;
		end
	end

	always_ff @(posedge aclk) begin
		if (buf_take)
			shift_reg <= buf_data;	// New byte replaces the spent one
		else if (tick)
			shift_reg <= shift_reg >> 1;
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			dmc_out <= '0;
		end else if (level_load) begin
			dmc_out <= level_value;	// Direct write wins over a step
		end else if (tick && !silence) begin
			if (step_up)
				dmc_out <= dmc_out + 7'd2;
			else if (step_down)
				dmc_out <= dmc_out - 7'd2;
		end
	end

endmodule

/* hdl/dmc_channel.sv */
// DMC channel top level
`timescale 1ns/10ps

module dmc_channel (
	input logic aclk,
	input logic reset,
	input dmc_pkg::sample_t data_in,
	input logic w4010,
	input logic w4011,
	input logic w4012,
	input logic w4013,
	input logic w4015,
	input logic cpu_read,
	output logic rdy,
	output logic dmc_ab,
	output dmc_pkg::addr_t dmc_addr,
	output logic dmc_int,
	output logic dmc_active,
	output dmc_pkg::level_t dmc_out
);

	logic tick;			// One output bit period elapsed
	logic buf_full;
	logic buf_take;
	dmc_pkg::sample_t buf_data;
	logic level_load;
	dmc_pkg::level_t level_value;

	dmc_cfg_if cfg_if ();

	dmc_regs dmc_regs_inst (
		.aclk        (aclk),
		.reset       (reset),
		.data_in     (data_in),
		.w4010       (w4010),
		.w4011       (w4011),
		.w4012       (w4012),
		.w4013       (w4013),
		.w4015       (w4015),
		.cfg         (cfg_if.regs),
		.level_load  (level_load),
		.level_value (level_value)
	);

	dmc_rate_timer dmc_rate_timer_inst (
		.aclk  (aclk),
		.reset (reset),
		.cfg   (cfg_if.timer),
		.tick  (tick)
	);

	dmc_reader dmc_reader_inst (
		.aclk       (aclk),
		.reset      (reset),
		.cfg        (cfg_if.reader),
		.cpu_read   (cpu_read),
		.data_in    (data_in),
		.buf_take   (buf_take),
		.rdy        (rdy),
		.dmc_ab     (dmc_ab),
		.dmc_addr   (dmc_addr),
		.buf_full   (buf_full),
		.buf_data   (buf_data),
		.dmc_int    (dmc_int),
		.dmc_active (dmc_active)
	);

	dmc_output_unit dmc_output_unit_inst (
		.aclk        (aclk),
		.reset       (reset),
		.tick        (tick),
		.buf_full    (buf_full),
		.buf_data    (buf_data),
		.level_load  (level_load),
		.level_value (level_value),
		.buf_take    (buf_take),
		.dmc_out     (dmc_out)
	);

endmodule

/* sim/dmc_sva.sv */
// DMC channel assertions
`timescale 1ns/10ps
`include "dmc_params.svh"

module dmc_sva (
	input logic aclk,
	input logic reset,
	input dmc_pkg::sample_t data_in,
	input logic w4010, w4011, w4012, w4013, w4015,
	input logic cpu_read,
	input logic rdy,
	input logic dmc_ab,
	input dmc_pkg::addr_t dmc_addr,
	input logic dmc_int,
	input logic dmc_active,
	input dmc_pkg::level_t dmc_out
);

	int fail_count = 0;
	dmc_pkg::sample_t start_q;	// Shadow of $4012
	dmc_pkg::sample_t len_q;	// Shadow of $4013
	logic loop_q;
	logic irq_q;
	dmc_pkg::addr_t exp_addr;	// Address the next fetch must use
	int exp_left;			// Fetches still due
	dmc_pkg::level_t load_q;	// Last $4011 value
	dmc_pkg::level_t prev_out;
	logic prev_load;
	logic last_fetch;

	assign last_fetch = dmc_ab && (exp_left == 1);

	always_ff @(posedge aclk) begin
		if (reset) begin
			start_q <= '0;
			len_q <= '0;
			loop_q <= 1'b0;
			irq_q <= 1'b0;
			exp_addr <= '0;
			exp_left <= 0;
			load_q <= '0;
			prev_out <= '0;
			prev_load <= 1'b1;	// Mask the first compare
		end else begin
			prev_out <= dmc_out;
			prev_load <= w4011;
			if (w4010) begin
				loop_q <= data_in[6];
				irq_q <= data_in[7];
			end
			if (w4011)
				load_q <= data_in[6:0];
			if (w4012)
				start_q <= data_in;
			if (w4013)
				len_q <= data_in;
			if (w4015 && !data_in[4]) begin
				exp_left <= 0;
			end else if (w4015 && exp_left == 0) begin
				exp_addr <= 16'hC000 + {start_q, 6'b0};	// 64 bytes per step
				exp_left <= 16 * len_q + 1;
			end
			if (dmc_ab) begin
				exp_addr <= (exp_addr == 16'hFFFF) ? 16'h8000 : exp_addr + 16'd1;
				exp_left <= exp_left - 1;
				if (last_fetch && loop_q) begin
					exp_addr <= 16'hC000 + {start_q, 6'b0};
					exp_left <= 16 * len_q + 1;
				end
			end
		end
	end

	reset_state: assert property (@(posedge aclk)
		reset |=> rdy && !dmc_ab && !dmc_int && dmc_out == '0)
	else begin
		fail_count++;
		$error("FAIL %0t reset outputs: rdy=%b dmc_ab=%b dmc_int=%b dmc_out=%0d expected 1 0 0 0",
			$time, $sampled(rdy), $sampled(dmc_ab), $sampled(dmc_int), $sampled(dmc_out));
	end

	grant_after_stall: assert property (@(posedge aclk) disable iff (reset)
		dmc_ab |-> $past(!rdy && cpu_read))
	else begin
		fail_count++;
		$error("dmc_ab went high without a stalled read cycle before it");
	end

	level_load: assert property (@(posedge aclk) disable iff (reset)
		w4011 |=> dmc_out == load_q)
	else begin
		fail_count++;
		$error("FAIL %0t dmc_out: got %0d expected %0d", $time, $sampled(dmc_out),
			$sampled(load_q));
	end

	level_step: assert property (@(posedge aclk) disable iff (reset)
		(!prev_load && dmc_out != prev_out) |->
		(dmc_out == prev_out + 7'd2 && prev_out <= `DMC_LEVEL_MAX - 2) ||
		(dmc_out == prev_out - 7'd2 && prev_out >= 7'd2))
	else begin
		fail_count++;
		$error("FAIL %0t dmc_out: got %0d expected %0d plus or minus 2", $time,
			$sampled(dmc_out), $sampled(prev_out));
	end

	fetch_addr: assert property (@(posedge aclk) disable iff (reset)
		dmc_ab |-> dmc_addr == exp_addr)
	else begin
		fail_count++;
		$error("FAIL %0t dmc_addr: got %h expected %h", $time, $sampled(dmc_addr),
			$sampled(exp_addr));
	end

	fetch_limit: assert property (@(posedge aclk) disable iff (reset)
		dmc_ab |-> exp_left != 0)
	else begin
		fail_count++;
		$error("A fetch happened after the whole sample was read");
	end

	active_fall: assert property (@(posedge aclk) disable iff (reset)
		$fell(dmc_active) |-> exp_left == 0)
	else begin
		fail_count++;
		$error("dmc_active fell with %0d fetches still missing", $sampled(exp_left));
	end

	irq_set: assert property (@(posedge aclk) disable iff (reset)
		(last_fetch && irq_q && !loop_q) |=> dmc_int)
	else begin
		fail_count++;
		$error("FAIL %0t dmc_int: got 0 expected 1 after the last byte", $time);
	end

	irq_clear: assert property (@(posedge aclk) disable iff (reset)
		w4015 |=> !dmc_int)
	else begin
		fail_count++;
		$error("FAIL %0t dmc_int: got 1 expected 0 after a $4015 write", $time);
	end

	loop_no_irq: assert property (@(posedge aclk) disable iff (reset)
		loop_q |=> !$rose(dmc_int))
	else begin
		fail_count++;
		$error("dmc_int rose during looped playback");
	end

endmodule

bind dmc_channel dmc_sva dmc_sva_inst (
	.aclk       (aclk),
	.reset      (reset),
	.data_in    (data_in),
	.w4010      (w4010),
	.w4011      (w4011),
	.w4012      (w4012),
	.w4013      (w4013),
	.w4015      (w4015),
	.cpu_read   (cpu_read),
	.rdy        (rdy),
	.dmc_ab     (dmc_ab),
	.dmc_addr   (dmc_addr),
	.dmc_int    (dmc_int),
	.dmc_active (dmc_active),
	.dmc_out    (dmc_out)
);

/* sim/tb_dmc.sv */
// DMC channel testbench
`timescale 1ns/10ps

module tb_dmc;

	logic aclk;
	logic reset;
	logic w4010, w4011, w4012, w4013, w4015;
	logic cpu_read;
	dmc_pkg::sample_t reg_data;	// CPU write data
	dmc_pkg::sample_t data_in;
	logic rdy, dmc_ab, dmc_int, dmc_active;
	dmc_pkg::addr_t dmc_addr;
	dmc_pkg::level_t dmc_out;
	int cycle_count = 0;
	int fetch_count = 0;
	int fetch_base;
	int seed_val;

	// 17 one-shot bytes at period 53, 67 looped bytes at period 27, plus half again
	localparam int cycle_limit = (17 * 8 * 53 + 67 * 8 * 27) * 3 / 2;

	// Sample memory answers with the low address byte
	assign data_in = dmc_ab ? dmc_addr[7:0] : reg_data;

	dmc_channel dmc_channel_inst (.*);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	initial begin
		cpu_read = 1'b0;
		seed_val = $urandom(8);
		forever begin
			@(posedge aclk);
			#1;
			cpu_read = $urandom % 2;	// Random mix of read and write cycles
		end
	end

	always @(posedge aclk) begin
		cycle_count++;
		if (dmc_ab)
			fetch_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, playback did not finish, failures: %0d",
				cycle_count, dmc_channel_inst.dmc_sva_inst.fail_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic wait_cycle();
		@(posedge aclk);
		#1;
	endtask

	// CPU register write, held off while the DMA owns the bus
	task automatic write_reg(input int addr, input dmc_pkg::sample_t value);
		while (!rdy)
			wait_cycle();
		reg_data = value;
		case (addr)
			'h4010: w4010 = 1'b1;
			'h4011: w4011 = 1'b1;
			'h4012: w4012 = 1'b1;
			'h4013: w4013 = 1'b1;
			default: w4015 = 1'b1;
		endcase
		wait_cycle();
		{w4010, w4011, w4012, w4013, w4015} = '0;
	endtask

	initial begin
		reset = 1'b1;
		{w4010, w4011, w4012, w4013, w4015} = '0;
		reg_data = '0;
		repeat (3) @(posedge aclk);
		#1;
		reset = 1'b0;
		write_reg('h4011, 8'h35);
		write_reg('h4011, 8'hFF);	// Bit 7 dropped, level 127
		// One-shot from C400, 17 bytes, interrupt on
		write_reg('h4010, 8'h8C);
		write_reg('h4012, 8'h10);
		write_reg('h4013, 8'h01);
		write_reg('h4015, 8'h10);
		while (!dmc_int)
			wait_cycle();
		write_reg('h4015, 8'h00);	// Acknowledge and stop
		// Looped from FFC0 with interrupt on, wraps to 8000, then restarts
		write_reg('h4010, 8'hCF);
		write_reg('h4012, 8'hFF);
		write_reg('h4013, 8'h04);
		fetch_base = fetch_count;
		write_reg('h4015, 8'h10);
		while (fetch_count < fetch_base + 67)
			wait_cycle();
		write_reg('h4015, 8'h00);	// Buffer is full here, no fetch pending
		while (dmc_active)
			wait_cycle();
		repeat (10) wait_cycle();
		$display("Fetches: %0d, assertion failures: %0d", fetch_count,
			dmc_channel_inst.dmc_sva_inst.fail_count);
		if (dmc_channel_inst.dmc_sva_inst.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+hdl
hdl/dmc_pkg.sv
hdl/dmc_cfg_if.sv
hdl/dmc_regs.sv
hdl/dmc_rate_timer.sv
hdl/dmc_reader.sv
hdl/dmc_output_unit.sv
hdl/dmc_channel.sv
sim/dmc_sva.sv
sim/tb_dmc.sv
